// File: ex_stage.f
+incdir+hw
hw/ex_pkg.sv
hw/ex_result_if.sv
hw/ex_alu.sv
hw/ex_mult.sv
hw/ex_writeback.sv
hw/ex_stage.sv
testbench/tb_ex_stage.sv

// File: hw/ex_alu.sv
`timescale 1ns/100ps
`include "ex_cfg.svh"

module ex_alu (
  input  logic            enable_i,
  input  ex_pkg::alu_op_e operator_i,
  input  ex_pkg::word_t   operand_a_i,
  input  ex_pkg::word_t   operand_b_i,
  output logic            cmp_result_o,
  ex_result_if.alu        res
);

  import ex_pkg::*;

  // mirror a word so the right shifter also does left shifts
  function automatic word_t bit_rev(input word_t val);
    word_t rev;
    for (int i = 0; i < `EX_XLEN; i++) begin
      rev[i] = val[`EX_XLEN-1-i];
    end
    return rev;
  endfunction

  logic                       adder_sub;
  logic                       cmp_signed;
  logic [`EX_XLEN:0]          adder_a;
  logic [`EX_XLEN:0]          adder_b;
  logic [`EX_XLEN:0]          adder_sum;
  logic                       is_less;
  logic                       is_equal;
  logic                       shift_left;
  logic                       shift_fill;
  logic [$clog2(`EX_XLEN)-1:0] shift_amt;
  word_t                      shift_in;
  logic [`EX_XLEN:0]          shift_ext;
  word_t                      shift_result;

  //////////////////////////////////////////////////
  // shared adder
  //////////////////////////////////////////////////

  // everything except add goes through the subtract path
  assign adder_sub  = (operator_i != ADD);
  assign cmp_signed = (operator_i inside {SLT, LT, GE});

  // one extra bit, sign or zero extended per compare type
  assign adder_a = {cmp_signed & operand_a_i[`EX_XLEN-1], operand_a_i};
  assign adder_b = {cmp_signed & operand_b_i[`EX_XLEN-1], operand_b_i};

  assign adder_sum = adder_a + (adder_sub ? ~adder_b : adder_b)
                   + {{`EX_XLEN{1'b0}}, adder_sub};

  // top bit of the extended difference is the less-than flag
  assign is_less  = adder_sum[`EX_XLEN];
  assign is_equal = (operand_a_i == operand_b_i);

  //////////////////////////////////////////////////
  // shared shifter
  //////////////////////////////////////////////////

  assign shift_left = (operator_i == SLL);
  assign shift_amt  = operand_b_i[$clog2(`EX_XLEN)-1:0];
  assign shift_in   = shift_left ? bit_rev(operand_a_i) : operand_a_i;
  // fill bit only for arithmetic right
  assign shift_fill = (operator_i == SRA) & operand_a_i[`EX_XLEN-1];

  assign shift_ext    = $signed({shift_fill, shift_in}) >>> shift_amt;
  assign shift_result = shift_left ? bit_rev(shift_ext[`EX_XLEN-1:0])
                                   : shift_ext[`EX_XLEN-1:0];

  // branch outcome
  always_comb begin
    case (operator_i)
      EQ:                     cmp_result_o = is_equal;
      NE:                     cmp_result_o = ~is_equal;
      LT, LTU, SLT, SLTU:     cmp_result_o = is_less;
      GE, GEU:                cmp_result_o = ~is_less;
      default:                cmp_result_o = 1'b0;
    endcase
  end

  // result mux, held at zero while idle
  always_comb begin
    res.alu_result = '0;
    if (enable_i) begin
      case (operator_i)
        ADD, SUB:  res.alu_result = adder_sum[`EX_XLEN-1:0];
        AND:       res.alu_result = operand_a_i & operand_b_i;
        OR:        res.alu_result = operand_a_i | operand_b_i;
        XOR:       res.alu_result = operand_a_i ^ operand_b_i;
        SLL, SRL,
        SRA:       res.alu_result = shift_result;
        default:   res.alu_result = {{(`EX_XLEN-1){1'b0}}, cmp_result_o};
      endcase
    end
  end

endmodule

// File: hw/ex_cfg.svh
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// fixed widths of the execute stage
// no module parameters, everything keys off these

// data word width
`define EX_XLEN   32

// register file address width
// upper half of the space is reserved for extra register banks
`define EX_REG_AW 6

// full product of two data words
// high-half ops return the upper EX_XLEN bits of this
`define EX_PROD_W 64

`endif

// File: hw/ex_mult.sv
`timescale 1ns/100ps
`include "ex_cfg.svh"

module ex_mult (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             enable_i,
  input  ex_pkg::mult_op_e operator_i,
  input  ex_pkg::word_t    op_a_i,
  input  ex_pkg::word_t    op_b_i,
  input  ex_pkg::word_t    op_c_i,
  output logic             multicycle_o,
  ex_result_if.mult        res
);

  import ex_pkg::*;

  typedef enum logic {
    ST_IDLE,
    ST_HIGH
  } mult_state_e;

  mult_state_e                  state_q;
  mult_state_e                  state_d;
  logic                         sign_a;
  logic                         sign_b;
  logic signed [`EX_XLEN:0]     mul_a;
  logic signed [`EX_XLEN:0]     mul_b;
  logic signed [2*`EX_XLEN+1:0] mul_full;
  logic [`EX_PROD_W-1:0]        product;
  logic [`EX_PROD_W-1:0]        product_q;
  logic                         is_high;
  word_t                        mac_sum;

  //////////////////////////////////////////////////
  // 33x33 signed multiplier
  //////////////////////////////////////////////////

  // extension bit per operand
  // low-half ops do not care, so they take zero
  assign sign_a = (operator_i inside {MULH, MULHSU}) & op_a_i[`EX_XLEN-1];
  assign sign_b = (operator_i == MULH) & op_b_i[`EX_XLEN-1];

  assign mul_a    = {sign_a, op_a_i};
  assign mul_b    = {sign_b, op_b_i};
  assign mul_full = mul_a * mul_b;
  assign product  = mul_full[`EX_PROD_W-1:0];

  // accumulate on the low half only
  assign mac_sum = product[`EX_XLEN-1:0] + op_c_i;

  assign is_high = enable_i & (operator_i inside {MULH, MULHSU, MULHU});

  //////////////////////////////////////////////////
  // high-half controller
  //////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    res.mult_ready = 1'b1;
    multicycle_o   = 1'b0;
    case (state_q)
      ST_IDLE: begin
        // issue cycle, stall id while the product is captured
        if (is_high) begin
          state_d        = ST_HIGH;
          res.mult_ready = 1'b0;
        end
      end
      ST_HIGH: begin
        multicycle_o = 1'b1;
        // hold the upper half under back-pressure
        if (res.ex_ready) begin
          state_d = ST_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // full product, loaded in the issue cycle
  always_ff @(posedge clk) begin
    if ((state_q == ST_IDLE) && is_high) begin
      product_q <= product;
    end
  end

  // result select
  always_comb begin
    if (state_q == ST_HIGH) begin
      res.mult_result = product_q[`EX_PROD_W-1:`EX_XLEN];
    end else begin
      case (operator_i)
        MUL:     res.mult_result = product[`EX_XLEN-1:0];
        MAC:     res.mult_result = mac_sum;
        default: res.mult_result = product[`EX_PROD_W-1:`EX_XLEN];
      endcase
    end
  end

endmodule

// File: hw/ex_pkg.sv
`include "ex_cfg.svh"

package ex_pkg;

  // one data word
  typedef logic [`EX_XLEN-1:0] word_t;

  // register file address
  typedef logic [`EX_REG_AW-1:0] reg_addr_t;

  // alu operators
  // last six are the branch comparisons
  typedef enum logic [4:0] {
    ADD  = 5'h00,
    SUB  = 5'h01,
    AND  = 5'h02,
    OR   = 5'h03,
    XOR  = 5'h04,
    SLL  = 5'h05,
    SRL  = 5'h06,
    SRA  = 5'h07,
    SLT  = 5'h08,
    SLTU = 5'h09,
    EQ   = 5'h10,
    NE   = 5'h11,
    LT   = 5'h12,
    GE   = 5'h13,
    LTU  = 5'h14,
    GEU  = 5'h15
  } alu_op_e;

  // multiplier operators
  typedef enum logic [2:0] {
    MUL    = 3'd0,
    MAC    = 3'd1,
    MULH   = 3'd2,
    MULHSU = 3'd3,
    MULHU  = 3'd4
  } mult_op_e;

endpackage

// File: hw/ex_result_if.sv
`timescale 1ns/100ps
`include "ex_cfg.svh"

// unit results toward write-back, stall feedback back to the units
interface ex_result_if;

  // alu result, zero while idle
  logic [`EX_XLEN-1:0] alu_result;
  // multiplier result, low or high half
  logic [`EX_XLEN-1:0] mult_result;
  // low only in the issue cycle of a high-half op
  logic                mult_ready;
  // stage accepts the next op on this edge
  logic                ex_ready;

  modport alu (output alu_result);

  modport mult (output mult_result, output mult_ready, input ex_ready);

  modport wb (
    input  alu_result,
    input  mult_result,
    input  mult_ready,
    output ex_ready
  );

endinterface

// File: hw/ex_stage.sv
`timescale 1ns/100ps

module ex_stage (
  input  logic              clk,
  input  logic              rst_n,
  // alu operation from id
  input  logic              alu_en_i,
  input  ex_pkg::alu_op_e   alu_operator_i,
  input  ex_pkg::word_t     alu_operand_a_i,
  input  ex_pkg::word_t     alu_operand_b_i,
  input  ex_pkg::word_t     alu_operand_c_i,
  // multiplier operation from id
  input  logic              mult_en_i,
  input  ex_pkg::mult_op_e  mult_operator_i,
  input  ex_pkg::word_t     mult_operand_a_i,
  input  ex_pkg::word_t     mult_operand_b_i,
  input  ex_pkg::word_t     mult_operand_c_i,
  output logic              mult_multicycle_o,
  // csr read
  input  logic              csr_access_i,
  input  ex_pkg::word_t     csr_rdata_i,
  // load/store unit
  input  logic              lsu_en_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  // write controls from id
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  // forwarding port
  output logic              regfile_alu_we_fw_o,
  output ex_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output ex_pkg::word_t     regfile_alu_wdata_fw_o,
  // load/store write port
  output logic              regfile_we_wb_o,
  output ex_pkg::reg_addr_t regfile_waddr_wb_o,
  output ex_pkg::word_t     regfile_wdata_wb_o,
  // branch to if
  input  logic              branch_in_ex_i,
  output logic              branch_decision_o,
  output ex_pkg::word_t     jump_target_o,
  // stall handshake
  input  logic              wb_ready_i,
  output logic              ex_valid_o,
  output logic              ex_ready_o
);

  import ex_pkg::*;

  ex_result_if res_if ();

  // target computed in id, ex only resolves the decision
  assign jump_target_o = alu_operand_c_i;
  assign ex_ready_o    = res_if.ex_ready;

  //////////////////////////////////////////////////
  // execution units
  //////////////////////////////////////////////////

  ex_alu alu_i (
    .enable_i     (alu_en_i),
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .cmp_result_o (branch_decision_o),
    .res          (res_if.alu)
  );

  ex_mult mult_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .op_c_i       (mult_operand_c_i),
    .multicycle_o (mult_multicycle_o),
    .res          (res_if.mult)
  );

  //////////////////////////////////////////////////
  // write ports and stall logic
  //////////////////////////////////////////////////

  ex_writeback wb_i (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .csr_rdata_i            (csr_rdata_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .lsu_err_i              (lsu_err_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .wb_ready_i             (wb_ready_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .ex_valid_o             (ex_valid_o),
    .res                    (res_if.wb)
  );

endmodule

// File: hw/ex_writeback.sv
`timescale 1ns/100ps

module ex_writeback (
  input  logic              clk,
  input  logic              rst_n,
  // unit enables from id
  input  logic              alu_en_i,
  input  logic              mult_en_i,
  input  logic              csr_access_i,
  input  logic              lsu_en_i,
  input  ex_pkg::word_t     csr_rdata_i,
  // alu port write controls
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  // load/store port write controls
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  // stall inputs
  input  logic              branch_in_ex_i,
  input  logic              wb_ready_i,
  // forwarding port toward rf and id
  output logic              regfile_alu_we_fw_o,
  output ex_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output ex_pkg::word_t     regfile_alu_wdata_fw_o,
  // load/store write port
  output logic              regfile_we_wb_o,
  output ex_pkg::reg_addr_t regfile_waddr_wb_o,
  output ex_pkg::word_t     regfile_wdata_wb_o,
  output logic              ex_valid_o,
  ex_result_if.wb           res
);

  import ex_pkg::*;

  logic      unit_active;
  logic      units_ready;
  logic      lsu_we;
  logic      we_q;
  reg_addr_t waddr_q;

  //////////////////////////////////////////////////
  // alu / forwarding write port
  //////////////////////////////////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // csr wins over mult, mult over alu
  always_comb begin
    regfile_alu_wdata_fw_o = '0;
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = res.mult_result;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = res.alu_result;
    end
  end

  //////////////////////////////////////////////////
  // valid / ready
  //////////////////////////////////////////////////

  assign unit_active = alu_en_i | mult_en_i | csr_access_i | lsu_en_i;
  assign units_ready = res.mult_ready & lsu_ready_ex_i & wb_ready_i;

  // valid flows forward, no dependence on ex_ready
  assign ex_valid_o   = unit_active & units_ready;
  // a branch finishes in ex and never waits on wb
  assign res.ex_ready = units_ready | branch_in_ex_i;

  //////////////////////////////////////////////////
  // ex/wb pipeline register
  //////////////////////////////////////////////////

  // a faulting access must not write the register file
  assign lsu_we = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q <= 1'b0;
    end else if (ex_valid_o) begin
      we_q <= lsu_we;
    end else if (wb_ready_i) begin
      // wb drained and nothing new, flush
      we_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_o && lsu_we) begin
      waddr_q <= regfile_waddr_i;
    end
  end

  assign regfile_we_wb_o    = we_q;
  assign regfile_waddr_wb_o = waddr_q;
  // load data arrives in the wb cycle
  assign regfile_wdata_wb_o = lsu_rdata_i;

endmodule

// File: testbench/ex_stimulus.txt
# unit op a b c we waddr err exp_fw exp_br   (a b c exp_fw hex, rest decimal)
# c is also csr data, load data and jump target; exp_br checked on branches only
alu ADD 00000005 00000007 00001000 1 1 0 0000000c 0
alu ADD ffffffff 00000001 00001004 1 2 0 00000000 0
alu SUB 00000003 00000005 00001008 1 3 0 fffffffe 0
alu AND f0f0f0f0 ff00ff00 00000000 1 4 0 f000f000 0
alu OR f0f0f0f0 0f0f0000 00000000 1 5 0 fffff0f0 0
alu XOR aaaaaaaa ffff0000 00000000 1 6 0 5555aaaa 0
alu SLL 00000001 0000001f 00000000 1 7 0 80000000 0
alu SLL 12345678 00000024 00000000 1 8 0 23456780 0
alu SRL 80000000 00000004 00000000 1 9 0 08000000 0
alu SRA 80000000 00000004 00000000 1 10 0 f8000000 0
alu SRA 7ffffff0 00000004 00000000 1 11 0 07ffffff 0
alu SLT ffffffff 00000001 00000000 1 12 0 00000001 0
alu SLTU ffffffff 00000001 00000000 1 13 0 00000000 0
alu EQ 0000abcd 0000abcd 00002000 0 0 0 00000001 1
alu EQ 0000abcd 0000abce 00002004 0 0 0 00000000 0
alu NE 0000abcd 0000abce 00002008 0 0 0 00000001 1
alu LT 80000000 7fffffff 0000200c 0 0 0 00000001 1
alu LT 7fffffff 80000000 00002010 0 0 0 00000000 0
alu GE 7fffffff 80000000 00002014 0 0 0 00000001 1
alu GE ffffffff ffffffff 00002018 0 0 0 00000001 1
alu LTU 7fffffff 80000000 0000201c 0 0 0 00000001 1
alu LTU 80000000 7fffffff 00002020 0 0 0 00000000 0
alu GEU 80000000 7fffffff 00002024 0 0 0 00000001 1
alu GEU 00000000 00000001 00002028 0 0 0 00000000 0
mult MUL 00000007 00000006 00000000 1 14 0 0000002a 0
mult MUL ffffffff ffffffff 00000000 1 15 0 00000001 0
mult MAC 00000003 00000004 00000005 1 16 0 00000011 0
mult MAC 00010000 00010000 00000001 1 17 0 00000001 0
mult MULH ffffffff 00000002 00000000 1 18 0 ffffffff 0
mult MULH 80000000 80000000 00000000 1 19 0 40000000 0
mult MULHSU ffffffff ffffffff 00000000 1 20 0 ffffffff 0
mult MULHSU 00000002 80000000 00000000 1 21 0 00000001 0
mult MULHU ffffffff ffffffff 00000000 1 22 0 fffffffe 0
mult MULHU 80000000 00000004 00000000 1 23 0 00000002 0
csr - 00000000 00000000 deadbeef 1 24 0 deadbeef 0
csr_alu ADD 00000001 00000002 cafef00d 1 25 0 cafef00d 0
csr_mult MUL 00000003 00000003 12345678 1 26 0 12345678 0
csr_mult MULHU ffffffff ffffffff 0badf00d 1 27 0 0badf00d 0
alu_mult MUL 00000003 00000005 00000000 1 28 0 0000000f 0
lsu - 00000000 00000000 11111111 1 30 0 00000000 0
lsu - 00000000 00000000 22222222 1 31 1 00000000 0
lsu - 00000000 00000000 33333333 0 32 0 00000000 0
lsu - 00000000 00000000 44444444 1 63 0 00000000 0
idle - 00000000 00000000 00000000 0 0 0 00000000 0
idle - 00000000 00000000 00000000 0 0 0 00000000 0

// File: testbench/tb_ex_stage.sv
`timescale 1ns/100ps

module tb_ex_stage;

  import ex_pkg::*;

  // cycles allowed for one handshake
  localparam int MAX_WAIT = 40;

  // dut ports, names match for the implicit connection
  logic      clk;
  logic      rst_n;
  logic      alu_en_i, mult_en_i, csr_access_i, lsu_en_i;
  alu_op_e   alu_operator_i;
  mult_op_e  mult_operator_i;
  word_t     alu_operand_a_i, alu_operand_b_i, alu_operand_c_i;
  word_t     mult_operand_a_i, mult_operand_b_i, mult_operand_c_i;
  word_t     csr_rdata_i, lsu_rdata_i;
  logic      lsu_ready_ex_i, lsu_err_i, branch_in_ex_i, wb_ready_i;
  logic      regfile_alu_we_i, regfile_we_i;
  reg_addr_t regfile_alu_waddr_i, regfile_waddr_i;
  logic      mult_multicycle_o, branch_decision_o, ex_valid_o, ex_ready_o;
  logic      regfile_alu_we_fw_o, regfile_we_wb_o;
  reg_addr_t regfile_alu_waddr_fw_o, regfile_waddr_wb_o;
  word_t     regfile_alu_wdata_fw_o, regfile_wdata_wb_o, jump_target_o;

  // one stimulus line
  string     unit;
  string     op;
  word_t     col_a, col_b, col_c, exp_fw;
  int        col_we, col_waddr, col_err, col_br;

  // per-line flags and the ex/wb register model
  logic      is_high, is_branch, any_en;
  logic      we_exp;
  reg_addr_t addr_exp;
  logic [31:0] lfsr;
  int        fd, got, ch, cycles, n_ops;
  bit        done, issue, accepted;

  ex_stage uut (.*);

  always #50 clk = ~clk;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Mismatch at time %0t: %s is %h, expected %h",
                                  $time, name, actual, expected));
    end
  endtask

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // enable mask, bit order lsu csr mult alu
  function automatic logic [3:0] decode_unit(input string name);
    if (name == "alu") return 4'b0001;
    if (name == "mult") return 4'b0010;
    if (name == "csr") return 4'b0100;
    if (name == "lsu") return 4'b1000;
    if (name == "csr_alu") return 4'b0101;
    if (name == "csr_mult") return 4'b0110;
    if (name == "alu_mult") return 4'b0011;
    return 4'b0000;
  endfunction

  // operator name lookup, -1 when not found
  function automatic int decode_alu(input string name);
    alu_op_e e;
    e = e.first();
    for (int i = 0; i < e.num(); i++) begin
      if (e.name() == name) return int'(e);
      e = e.next();
    end
    return -1;
  endfunction

  function automatic int decode_mult(input string name);
    mult_op_e e;
    e = e.first();
    for (int i = 0; i < e.num(); i++) begin
      if (e.name() == name) return int'(e);
      e = e.next();
    end
    return -1;
  endfunction

  //////////////////////////////////////////////////
  // drive and check
  //////////////////////////////////////////////////

  task automatic drive_line;
    logic [3:0] units;
    int         acode;
    int         mcode;
    units = decode_unit(unit);
    acode = decode_alu(op);
    mcode = decode_mult(op);
    if (units == 4'b0000 && unit != "idle") stop_with_failure({"unknown unit ", unit});
    if (acode < 0 && mcode < 0 && op != "-") stop_with_failure({"unknown operator ", op});
    alu_en_i     = units[0];
    mult_en_i    = units[1];
    csr_access_i = units[2];
    lsu_en_i     = units[3];
    // unused side of a combined line idles on ADD / MUL
    alu_operator_i   = (acode < 0) ? ADD : alu_op_e'(acode);
    mult_operator_i  = (mcode < 0) ? MUL : mult_op_e'(mcode);
    alu_operand_a_i  = col_a;
    alu_operand_b_i  = col_b;
    alu_operand_c_i  = col_c;
    mult_operand_a_i = col_a;
    mult_operand_b_i = col_b;
    mult_operand_c_i = col_c;
    // column c doubles as csr and load data
    csr_rdata_i = units[2] ? col_c : '0;
    lsu_rdata_i = units[3] ? col_c : '0;
    regfile_alu_we_i    = col_we[0] & ~units[3];
    regfile_alu_waddr_i = col_waddr[5:0];
    regfile_we_i        = col_we[0] & units[3];
    regfile_waddr_i     = col_waddr[5:0];
    lsu_err_i           = col_err[0] & units[3];
    is_branch = units[0] && (alu_operator_i inside {EQ, NE, LT, GE, LTU, GEU});
    is_high   = units[1] && (mult_operator_i inside {MULH, MULHSU, MULHU});
    any_en    = |units;
    branch_in_ex_i = is_branch;
  endtask

  // one clock, entered and left on a falling edge
  task automatic step_cycle(input bit first, output bit acc);
    logic exp_ready;
    logic exp_valid;
    lfsr       = lfsr_step(lfsr);
    wb_ready_i = lfsr[0];
    #10;
    // stall rules
    exp_ready = (!first && wb_ready_i) || branch_in_ex_i;
    exp_valid = any_en && !first && wb_ready_i;
    compare_value("ex_ready_o", ex_ready_o, exp_ready);
    compare_value("ex_valid_o", ex_valid_o, exp_valid);
    compare_value("jump_target_o", jump_target_o, col_c);
    compare_value("regfile_alu_we_fw_o", regfile_alu_we_fw_o, regfile_alu_we_i);
    compare_value("regfile_alu_waddr_fw_o", regfile_alu_waddr_fw_o, regfile_alu_waddr_i);
    compare_value("mult_multicycle_o", mult_multicycle_o, is_high && !first);
    // high-half data only exists after the issue cycle
    if (!(is_high && first)) begin
      compare_value("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, exp_fw);
    end
    if (is_branch) begin
      compare_value("branch_decision_o", branch_decision_o, col_br[0]);
    end
    @(posedge clk);
    // ex/wb register model
    if (exp_valid) begin
      we_exp = regfile_we_i & ~lsu_err_i;
      if (we_exp) addr_exp = regfile_waddr_i;
    end else if (wb_ready_i) begin
      we_exp = 1'b0;
    end
    @(negedge clk);
    compare_value("regfile_we_wb_o", regfile_we_wb_o, we_exp);
    if (we_exp) begin
      compare_value("regfile_waddr_wb_o", regfile_waddr_wb_o, addr_exp);
      compare_value("regfile_wdata_wb_o", regfile_wdata_wb_o, lsu_rdata_i);
    end
    acc = exp_ready;
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    unit = "idle";
    op = "-";
    col_a = '0;
    col_b = '0;
    col_c = '0;
    col_we = 0;
    col_waddr = 0;
    col_err = 0;
    drive_line();
    lsu_ready_ex_i = 1'b1;
    wb_ready_i = 1'b0;
    lfsr = 32'hc41b;
    we_exp = 1'b0;
    n_ops = 0;
    done = 0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    compare_value("regfile_we_wb_o", regfile_we_wb_o, 1'b0);
    compare_value("mult_multicycle_o", mult_multicycle_o, 1'b0);
    fd = $fopen("testbench/ex_stimulus.txt", "r");
    if (fd == 0) stop_with_failure("could not open testbench/ex_stimulus.txt");
    while (!done) begin
      if ($fscanf(fd, "%s", unit) != 1) begin
        done = 1;
      end else if (unit.substr(0, 0) == "#") begin
        // skip the rest of a comment line
        ch = $fgetc(fd);
        while (ch != "\n" && ch != -1) ch = $fgetc(fd);
      end else begin
        got = $fscanf(fd, "%s %h %h %h %d %d %d %h %d", op, col_a, col_b, col_c,
                      col_we, col_waddr, col_err, exp_fw, col_br);
        if (got != 9) stop_with_failure({"malformed stimulus line for unit ", unit});
        drive_line();
        // id holds the op until ex_ready_o
        issue = is_high;
        accepted = 0;
        cycles = 0;
        while (!accepted) begin
          if (cycles >= MAX_WAIT) begin
            stop_with_failure({"ex_ready_o never rose for ", unit, " ", op});
          end
          step_cycle(issue, accepted);
          issue = 0;
          cycles++;
        end
        n_ops++;
      end
    end
    $fclose(fd);
    if (n_ops == 0) begin
      stop_with_failure("stimulus file held no operations");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule
